// File: rtl/rob_config.svh
/* sizing macros for the reorder buffer: entry count, register file sizes, address width */

`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// number of slots in the reorder buffer, kept a power of two so the pointers wrap cleanly
`define ROB_SIZE 8

// physical register file size, sets the width of a renamed destination tag
`define PRF_SIZE 64

// architectural register file size, sets the width of a logical destination number
`define ARF_SIZE 32

// width of a program counter or a branch target address
`define PC_WIDTH 64

`endif

// File: rtl/rob_pkg.sv
/* shared vector types for the reorder buffer and its testbench */

package rob_pkg;

	`include "rob_config.svh"

	// instruction address or resolved branch target
	typedef logic [`PC_WIDTH-1:0] pc_t;

	// logical destination register as named by the instruction
	typedef logic [$clog2(`ARF_SIZE)-1:0] arn_t;

	// physical register the renamer assigned to the destination
	typedef logic [$clog2(`PRF_SIZE)-1:0] prn_t;

	// slot number inside the buffer, also used for the head and tail pointers
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_index_t;

	// occupancy, one bit wider than the index so that a full buffer can be told from an empty one
	typedef logic [$clog2(`ROB_SIZE+1)-1:0] rob_count_t;

endpackage

// File: rtl/rob_entry_if.sv
/* connection between the buffer controller and one slot: strobes and dispatch fields in,
   stored state out */
`timescale 1ns/100ps

interface rob_entry_if;
	import rob_pkg::*;

	logic       load;                // write the dispatch fields into this slot
	pc_t        dispatch_pc;         // address of the instruction being dispatched
	arn_t       dispatch_arn;        // its logical destination
	prn_t       dispatch_prn;        // its physical destination
	logic       dispatch_is_branch;  // the instruction is a branch
	logic       dispatch_predict;    // direction the front end predicted
	logic       dispatch_halt;       // the instruction stops the machine at commit
	logic       dispatch_illegal;    // the instruction failed to decode
	logic       complete;            // execution of this slot finished this cycle
	logic       complete_mispredict; // the branch outcome disagreed with the prediction
	pc_t        complete_target;     // where a mispredicted branch really goes
	logic       retire;              // the slot is at the head and commits this cycle
	logic       flush;               // a mispredict commits, every slot drops its contents

	logic       inuse;               // slot holds a live instruction
	logic       executed;            // completion has been seen
	pc_t        pc;
	arn_t       arn_dest;
	prn_t       prn_dest;
	logic       is_branch;
	logic       predict;
	logic       mispredict;
	pc_t        target_pc;
	logic       halt;
	logic       illegal;

	modport entry
	(
		input  load, dispatch_pc, dispatch_arn, dispatch_prn, dispatch_is_branch,
		input  dispatch_predict, dispatch_halt, dispatch_illegal,
		input  complete, complete_mispredict, complete_target, retire, flush,
		output inuse, executed, pc, arn_dest, prn_dest, is_branch, predict,
		output mispredict, target_pc, halt, illegal
	);

	modport ctrl
	(
		output load, dispatch_pc, dispatch_arn, dispatch_prn, dispatch_is_branch,
		output dispatch_predict, dispatch_halt, dispatch_illegal,
		output complete, complete_mispredict, complete_target, retire, flush,
		input  inuse, executed, pc, arn_dest, prn_dest, is_branch, predict,
		input  mispredict, target_pc, halt, illegal
	);

endinterface

// File: rtl/rob_entry.sv
/* one reorder buffer slot: holds a dispatched instruction's fields and tracks its
   completion and branch outcome until it retires or is flushed */
`timescale 1ns/100ps

module rob_entry
(
	input  logic       clock,
	input  logic       reset,
	rob_entry_if.entry slot
);
	import rob_pkg::*;

	// status bits, these decide whether the slot is live and may commit
	logic inuse;
	logic executed;
	logic mispredict;

	// instruction payload, only meaningful while inuse is set
	pc_t  pc;
	arn_t arn_dest;
	prn_t prn_dest;
	logic is_branch;
	logic predict;
	pc_t  target_pc;
	logic halt;
	logic illegal;

	logic next_inuse;
	logic next_executed;
	logic next_mispredict;
	pc_t  next_pc;
	arn_t next_arn_dest;
	prn_t next_prn_dest;
	logic next_is_branch;
	logic next_predict;
	pc_t  next_target_pc;
	logic next_halt;
	logic next_illegal;

	always_comb
	begin
		next_inuse      = inuse;                 // hold by default
		next_executed   = executed;
		next_mispredict = mispredict;
		next_pc         = pc;
		next_arn_dest   = arn_dest;
		next_prn_dest   = prn_dest;
		next_is_branch  = is_branch;
		next_predict    = predict;
		next_target_pc  = target_pc;
		next_halt       = halt;
		next_illegal    = illegal;
		if (slot.load)
		begin
			next_inuse      = 1'b1;                    // slot is claimed by the new instruction
			next_executed   = 1'b0;                    // execution status starts over
			next_mispredict = 1'b0;
			next_target_pc  = '0;
			next_pc         = slot.dispatch_pc;
			next_arn_dest   = slot.dispatch_arn;
			next_prn_dest   = slot.dispatch_prn;
			next_is_branch  = slot.dispatch_is_branch;
			next_predict    = slot.dispatch_predict;
			next_halt       = slot.dispatch_halt;
			next_illegal    = slot.dispatch_illegal;
		end
		else if (inuse && slot.complete)
		begin
			next_executed   = 1'b1;                    // a stray completion to a free slot is ignored
			next_mispredict = slot.complete_mispredict;
			next_target_pc  = slot.complete_target;
		end
		else if (slot.retire || slot.flush)
		begin
			next_inuse      = 1'b0;                    // slot becomes free at the next edge
			next_executed   = 1'b0;
			next_mispredict = 1'b0;
			next_pc         = '0;
			next_arn_dest   = '0;
			next_prn_dest   = '0;
			next_is_branch  = 1'b0;
			next_predict    = 1'b0;
			next_target_pc  = '0;
			next_halt       = 1'b0;
			next_illegal    = 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			inuse      <= 1'b0;
			executed   <= 1'b0;
			mispredict <= 1'b0;
		end
		else
		begin
			inuse      <= next_inuse;
			executed   <= next_executed;
			mispredict <= next_mispredict;
		end
	end

	always_ff @(posedge clock)
	begin
		pc        <= next_pc;
		arn_dest  <= next_arn_dest;
		prn_dest  <= next_prn_dest;
		is_branch <= next_is_branch;
		predict   <= next_predict;
		target_pc <= next_target_pc;
		halt      <= next_halt;
		illegal   <= next_illegal;
	end

	assign slot.inuse      = inuse;
	assign slot.executed   = executed;
	assign slot.mispredict = mispredict;
	assign slot.pc         = pc;
	assign slot.arn_dest   = arn_dest;
	assign slot.prn_dest   = prn_dest;
	assign slot.is_branch  = is_branch;
	assign slot.predict    = predict;
	assign slot.target_pc  = target_pc;
	assign slot.halt       = halt;
	assign slot.illegal    = illegal;

endmodule

// File: rtl/reorder_buffer.sv
/* reorder buffer controller: head, tail and count pointers, the slot array,
   per-slot strobe decode, head commit mux and mispredict flush */
`timescale 1ns/100ps
`include "rob_config.svh"

module reorder_buffer
(
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  rob_pkg::pc_t       dispatch_pc,
	input  rob_pkg::arn_t      dispatch_arn,
	input  rob_pkg::prn_t      dispatch_prn,
	input  logic               dispatch_is_branch,
	input  logic               dispatch_predict,
	input  logic               dispatch_halt,
	input  logic               dispatch_illegal,
	output logic               full,
	output logic               empty,
	output rob_pkg::rob_index_t dispatch_index,
	input  logic               complete_valid,
	input  rob_pkg::rob_index_t complete_index,
	input  logic               complete_mispredict,
	input  rob_pkg::pc_t       complete_target,
	input  logic               commit_stall,
	output logic               commit_valid,
	output rob_pkg::pc_t       commit_pc,
	output rob_pkg::arn_t      commit_arn,
	output rob_pkg::prn_t      commit_prn,
	output logic               commit_halt,
	output logic               commit_illegal,
	output logic               flush,
	output rob_pkg::pc_t       flush_target
);
	import rob_pkg::*;

	rob_index_t head;    // oldest live instruction
	rob_index_t tail;    // next free slot
	rob_count_t count;   // live instructions

	logic accept;        // dispatch is taken this cycle
	logic do_commit;     // head retires this cycle

	// slot state gathered into arrays so the head can be picked with a variable index
	logic entry_inuse      [`ROB_SIZE];
	logic entry_executed   [`ROB_SIZE];
	logic entry_is_branch  [`ROB_SIZE];
	logic entry_mispredict [`ROB_SIZE];
	logic entry_halt       [`ROB_SIZE];
	logic entry_illegal    [`ROB_SIZE];
	pc_t  entry_pc         [`ROB_SIZE];
	pc_t  entry_target     [`ROB_SIZE];
	arn_t entry_arn        [`ROB_SIZE];
	prn_t entry_prn        [`ROB_SIZE];

	rob_entry_if slots [`ROB_SIZE] ();

	// pointer increment with an explicit wrap at the last slot
	function automatic rob_index_t next_index(input rob_index_t index);
		if (index == rob_index_t'(`ROB_SIZE - 1))
			return '0;
		return rob_index_t'(index + 1'b1);
	endfunction

	assign full           = (count == rob_count_t'(`ROB_SIZE));
	assign empty          = (count == '0);
	assign dispatch_index = tail;                        // the renamer tags the instruction with this

	assign commit_valid = entry_inuse[head] && entry_executed[head]; // only a finished head commits
	assign do_commit    = commit_valid && !commit_stall;
	assign flush        = do_commit && entry_is_branch[head] && entry_mispredict[head];
	assign accept       = dispatch_valid && !full && !flush; // a dispatch beside a flush is dropped

	// commit fields read as zero unless a commit is offered
	assign commit_pc      = commit_valid ? entry_pc[head] : '0;
	assign commit_arn     = commit_valid ? entry_arn[head] : '0;
	assign commit_prn     = commit_valid ? entry_prn[head] : '0;
	assign commit_halt    = commit_valid && entry_halt[head];
	assign commit_illegal = commit_valid && entry_illegal[head];
	assign flush_target   = flush ? entry_target[head] : '0;

	for (genvar i = 0; i < `ROB_SIZE; i++)
	begin : g_slot
		assign slots[i].load               = accept && (tail == rob_index_t'(i));
		assign slots[i].dispatch_pc        = dispatch_pc;       // fields go to every slot, load picks one
		assign slots[i].dispatch_arn       = dispatch_arn;
		assign slots[i].dispatch_prn       = dispatch_prn;
		assign slots[i].dispatch_is_branch = dispatch_is_branch;
		assign slots[i].dispatch_predict   = dispatch_predict;
		assign slots[i].dispatch_halt      = dispatch_halt;
		assign slots[i].dispatch_illegal   = dispatch_illegal;
		assign slots[i].retire             = do_commit && (head == rob_index_t'(i));
		// a completion never competes with the clearing of its own slot
		assign slots[i].complete            = complete_valid && (complete_index == rob_index_t'(i))
			&& !flush && !slots[i].retire;
		assign slots[i].complete_mispredict = complete_mispredict;
		assign slots[i].complete_target     = complete_target;
		assign slots[i].flush               = flush;

		rob_entry i_rob_entry
		(
			.clock (clock),
			.reset (reset),
			.slot  (slots[i])
		);

		assign entry_inuse[i]      = slots[i].inuse;
		assign entry_executed[i]   = slots[i].executed;
		assign entry_is_branch[i]  = slots[i].is_branch;
		assign entry_mispredict[i] = slots[i].mispredict;
		assign entry_halt[i]       = slots[i].halt;
		assign entry_illegal[i]    = slots[i].illegal;
		assign entry_pc[i]         = slots[i].pc;
		assign entry_target[i]     = slots[i].target_pc;
		assign entry_arn[i]        = slots[i].arn_dest;
		assign entry_prn[i]        = slots[i].prn_dest;
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			head  <= '0;                                 // a flush restarts allocation at slot 0
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			if (accept)
				tail <= next_index(tail);
			if (do_commit)
				head <= next_index(head);
			case ({accept, do_commit})
				2'b10:   count <= rob_count_t'(count + 1'b1);
				2'b01:   count <= rob_count_t'(count - 1'b1);
				default: count <= count;                 // both or neither leave occupancy alone
			endcase
		end
	end

endmodule

// File: rtl/rob_top.sv
/* top level of the reorder buffer with plain dispatch, completion, commit and status ports */
`timescale 1ns/100ps

module rob_top
(
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  rob_pkg::pc_t       dispatch_pc,
	input  rob_pkg::arn_t      dispatch_arn,
	input  rob_pkg::prn_t      dispatch_prn,
	input  logic               dispatch_is_branch,
	input  logic               dispatch_predict,
	input  logic               dispatch_halt,
	input  logic               dispatch_illegal,
	output logic               full,
	output logic               empty,
	output rob_pkg::rob_index_t dispatch_index,
	input  logic               complete_valid,
	input  rob_pkg::rob_index_t complete_index,
	input  logic               complete_mispredict,
	input  rob_pkg::pc_t       complete_target,
	input  logic               commit_stall,
	output logic               commit_valid,
	output rob_pkg::pc_t       commit_pc,
	output rob_pkg::arn_t      commit_arn,
	output rob_pkg::prn_t      commit_prn,
	output logic               commit_halt,
	output logic               commit_illegal,
	output logic               flush,
	output rob_pkg::pc_t       flush_target
);

	reorder_buffer i_reorder_buffer
	(
		.clock               (clock),
		.reset               (reset),
		.dispatch_valid      (dispatch_valid),     // one instruction per cycle from rename
		.dispatch_pc         (dispatch_pc),
		.dispatch_arn        (dispatch_arn),
		.dispatch_prn        (dispatch_prn),
		.dispatch_is_branch  (dispatch_is_branch),
		.dispatch_predict    (dispatch_predict),
		.dispatch_halt       (dispatch_halt),
		.dispatch_illegal    (dispatch_illegal),
		.full                (full),               // stalls dispatch
		.empty               (empty),
		.dispatch_index      (dispatch_index),
		.complete_valid      (complete_valid),     // results arrive in any order
		.complete_index      (complete_index),
		.complete_mispredict (complete_mispredict),
		.complete_target     (complete_target),
		.commit_stall        (commit_stall),       // retirement back-pressure
		.commit_valid        (commit_valid),
		.commit_pc           (commit_pc),
		.commit_arn          (commit_arn),
		.commit_prn          (commit_prn),
		.commit_halt         (commit_halt),
		.commit_illegal      (commit_illegal),
		.flush               (flush),              // redirects fetch to flush_target
		.flush_target        (flush_target)
	);

endmodule

// File: verif/rob_properties.sv
/* concurrent checks on the reorder buffer status and commit outputs, bound into rob_top */
`timescale 1ns/100ps

module rob_properties
(
	input logic clock,
	input logic reset,
	input logic commit_valid,
	input logic empty,
	input logic full,
	input logic flush
);
	int failures = 0; // number of assertion failures so far

	a_no_commit_when_empty : assert property (@(posedge clock) disable iff (reset)
		!(commit_valid && empty))
		else
		begin
			failures++;
			$error("commit offered while the buffer is empty");
		end

	a_flush_needs_commit : assert property (@(posedge clock) disable iff (reset)
		flush |-> commit_valid) // a flush only comes from the committing head
		else
		begin
			failures++;
			$error("flush raised without a commit");
		end

	a_empty_after_flush : assert property (@(posedge clock) disable iff (reset) flush |=> empty)
		else
		begin
			failures++;
			$error("buffer not empty in the cycle after a flush");
		end

	a_not_full_and_empty : assert property (@(posedge clock) disable iff (reset)
		!(full && empty))
		else
		begin
			failures++;
			$error("full and empty both high");
		end

	a_reset_state : assert property (@(posedge clock)
		$fell(reset) |-> empty && !full && !commit_valid && !flush)
		else
		begin
			failures++;
			$error("status outputs wrong right after reset");
		end

endmodule

bind rob_top rob_properties i_rob_properties
(
	.clock        (clock),
	.reset        (reset),
	.commit_valid (commit_valid),
	.empty        (empty),
	.full         (full),
	.flush        (flush)
);

// File: verif/rob_tb.sv
/* reorder buffer testbench: clock, reset, LFSR stimulus, expected commit queue with
   checking assertions, six directed tests and the closing verdict */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_tb;
	import rob_pkg::*;

	localparam int timeout_cycles = 2000; // each test drains in well under 100 cycles

	typedef struct packed
	{
		pc_t        pc;
		arn_t       arn;
		prn_t       prn;
		rob_index_t index;
		logic       is_branch;
		logic       halt;
		logic       illegal;
	} expect_t;

	logic clock = 1'b0;
	logic reset;
	logic dispatch_valid, dispatch_is_branch, dispatch_predict, dispatch_halt, dispatch_illegal;
	pc_t dispatch_pc, complete_target, commit_pc, flush_target;
	arn_t dispatch_arn, commit_arn;
	prn_t dispatch_prn, commit_prn;
	rob_index_t dispatch_index, complete_index;
	logic full, empty, complete_valid, complete_mispredict, commit_stall;
	logic commit_valid, commit_halt, commit_illegal, flush;

	expect_t expected_q [$];              // dispatched instructions not yet committed with the oldest in front
	expect_t front;
	rob_index_t expected_tail = '0;       // slot the next accepted dispatch should get
	logic completed [`ROB_SIZE];          // completion has been given to that slot
	logic mispredict_given [`ROB_SIZE];
	pc_t target_given [`ROB_SIZE];
	logic model_full, mispredicted;
	logic was_stalled = 1'b0;             // head was offered and held off in the last cycle
	logic [31:0] lfsr = 32'h88222510;
	string test_name = "reset";
	int error_count = 0;
	int errors_before, tests_run = 0, tests_failed = 0;
	int commit_count = 0, flush_count = 0, cycle_count = 0;

	rob_top i_rob_top (.*);

	always #4 clock = ~clock;

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]}; // one step per bit taken
		end
	endtask

	task automatic value_error(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
	endtask

	task automatic plain_error(input string what);
		error_count++;
		$display("%s failed: %s", test_name, what);
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errors_before = error_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (error_count != errors_before)
			tests_failed++;
		$display("%s: %0d errors", test_name, error_count - errors_before);
	endtask

	// holds dispatch_valid until the buffer takes the instruction with random registers
	task automatic dispatch_one(input pc_t pc, input logic is_branch, input logic halt,
		input logic illegal, output rob_index_t index);
		logic [31:0] bits;
		logic taken;
		take_bits(11, bits);
		dispatch_valid     = 1'b1;
		dispatch_pc        = pc;
		dispatch_arn       = arn_t'(bits[10:6]);
		dispatch_prn       = prn_t'(bits[5:0]);
		dispatch_is_branch = is_branch;
		dispatch_halt      = halt;
		dispatch_illegal   = illegal;
		do
		begin
			@(negedge clock);
			taken = !full && !flush;
			index = dispatch_index;
			@(posedge clock);
			#1;
		end
		while (!taken);
		dispatch_valid    = 1'b0;
		completed[index]  = 1'b0;     // the slot now holds a fresh instruction
	endtask

	task automatic complete_one(input rob_index_t index, input logic mispredict, input pc_t target);
		complete_valid      = 1'b1;
		complete_index      = index;
		complete_mispredict = mispredict;
		complete_target     = target;
		@(posedge clock);
		#1;
		completed[index]        = 1'b1;
		mispredict_given[index] = mispredict;
		target_given[index]     = target;
		complete_valid          = 1'b0;
		complete_mispredict     = 1'b0;
	endtask

	task automatic wait_drained();
		do
		begin
			@(posedge clock);
			#1;
		end
		while (expected_q.size() != 0 || !empty);
	endtask

	// checks every offered commit against the oldest dispatched instruction
	always @(negedge clock)
	begin
		if (reset)
		begin
			expected_q.delete();
			expected_tail = '0;
		end
		else
		begin
			model_full   = (expected_q.size() == `ROB_SIZE);
			mispredicted = 1'b0;
			assert (full == model_full) else value_error("full", model_full, full);
			assert (empty == (expected_q.size() == 0))
				else value_error("empty", expected_q.size() == 0, empty);
			if (commit_valid)
			begin
				assert (expected_q.size() != 0)
					else plain_error("commit offered with no instruction outstanding");
				if (expected_q.size() != 0)
				begin
					front = expected_q[0];
					assert (completed[front.index])
						else plain_error("head offered for commit before it completed");
					assert (commit_pc == front.pc) else value_error("commit pc", front.pc, commit_pc);
					assert (commit_arn == front.arn) else value_error("commit arn", front.arn, commit_arn);
					assert (commit_prn == front.prn) else value_error("commit prn", front.prn, commit_prn);
					assert (commit_halt == front.halt)
						else value_error("commit halt", front.halt, commit_halt);
					assert (commit_illegal == front.illegal)
						else value_error("commit illegal", front.illegal, commit_illegal);
					mispredicted = !commit_stall && front.is_branch && mispredict_given[front.index];
					assert (flush == mispredicted) else value_error("flush", mispredicted, flush);
					assert (!flush || flush_target == target_given[front.index])
						else value_error("flush target", target_given[front.index], flush_target);
					if (!commit_stall)
					begin
						void'(expected_q.pop_front());
						commit_count++;
					end
				end
				if (mispredicted)
				begin
					expected_q.delete();  // younger instructions are squashed
					expected_tail = '0;
					flush_count++;
				end
			end
			else
				assert (!was_stalled) else plain_error("commit offer withdrawn under stall");
			was_stalled = commit_valid && commit_stall;
			if (dispatch_valid && !model_full && !mispredicted)
			begin
				assert (dispatch_index == expected_tail)
					else value_error("dispatch index", expected_tail, dispatch_index);
				expected_q.push_back('{dispatch_pc, dispatch_arn, dispatch_prn, expected_tail,
					dispatch_is_branch, dispatch_halt, dispatch_illegal});
				expected_tail++;
			end
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count == timeout_cycles)
		begin
			$display("run stopped after %0d cycles, %s did not finish", cycle_count, test_name);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		rob_index_t index [9];
		rob_index_t order [8];
		logic [31:0] bits;
		int j, saved, total;
		{dispatch_valid, dispatch_is_branch, dispatch_predict, dispatch_halt} = '0;
		{dispatch_illegal, complete_valid, complete_mispredict, commit_stall} = '0;
		{dispatch_pc, dispatch_arn, dispatch_prn, complete_index, complete_target} = '0;
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		assert (empty && !full && !commit_valid && !flush) else plain_error("status wrong after reset");

		start_test("in_order_retire");
		for (int i = 0; i < 8; i++)
			dispatch_one(pc_t'('h1000 + 4 * i), 1'b0, 1'b0, 1'b0, index[i]);
		for (int i = 0; i < 8; i++)
			order[i] = rob_index_t'(i);
		for (int i = 7; i > 0; i--)
		begin
			take_bits(3, bits);
			j = bits % (i + 1);
			{order[i], order[j]} = {order[j], order[i]};
		end
		for (int i = 0; i < 8; i++)
			complete_one(index[order[i]], 1'b0, '0);
		wait_drained();
		finish_test();

		start_test("no_early_commit");
		for (int i = 0; i < 4; i++)
			dispatch_one(pc_t'('h2000 + 4 * i), 1'b0, 1'b0, 1'b0, index[i]);
		for (int i = 3; i > 0; i--)
			complete_one(index[i], 1'b0, '0);
		repeat (4) @(posedge clock);
		#1;
		assert (!commit_valid) else plain_error("commit offered before the head completed");
		complete_one(index[0], 1'b0, '0);
		wait_drained();
		finish_test();

		start_test("full_stall");
		for (int i = 0; i < 8; i++)
			dispatch_one(pc_t'('h3000 + 4 * i), 1'b0, 1'b0, 1'b0, index[i]);
		assert (full) else plain_error("buffer not full after eight dispatches");
		saved = commit_count;
		fork
			begin
				dispatch_one(pc_t'('h3020), 1'b0, 1'b0, 1'b0, index[8]);
				assert (commit_count == saved + 1)
					else plain_error("dispatch accepted while the buffer was full");
			end
			begin
				repeat (3) @(posedge clock);
				#1;
				complete_one(index[0], 1'b0, '0);
			end
		join
		for (int i = 1; i < 9; i++)
			complete_one(index[i], 1'b0, '0);
		wait_drained();
		finish_test();

		start_test("commit_stall");
		commit_stall = 1'b1;
		for (int i = 0; i < 6; i++)
			dispatch_one(pc_t'('h4000 + 4 * i), 1'b0, 1'b0, 1'b0, index[i]);
		for (int i = 0; i < 6; i++)
			complete_one(index[i], 1'b0, '0);
		repeat (3) @(posedge clock);
		#1;
		while (expected_q.size() != 0)
		begin
			take_bits(1, bits);
			commit_stall = bits[0];  // random back-pressure while the buffer drains
			@(posedge clock);
			#1;
		end
		commit_stall = 1'b0;
		wait_drained();
		finish_test();

		start_test("mispredict_flush");
		for (int i = 0; i < 5; i++)
			dispatch_one(pc_t'('h5000 + 4 * i), i == 1, 1'b0, 1'b0, index[i]);
		saved = flush_count;
		complete_one(index[2], 1'b0, '0);
		complete_one(index[3], 1'b0, '0);
		complete_one(index[0], 1'b0, '0);
		complete_one(index[1], 1'b1, pc_t'('h9000));
		while (flush_count == saved)
		begin
			@(posedge clock);
			#1;
		end
		assert (empty) else plain_error("buffer not empty after the flush");
		dispatch_one(pc_t'('h9000), 1'b0, 1'b0, 1'b0, index[8]);
		assert (index[8] == 0) else value_error("index after flush", 0, index[8]);
		complete_one(index[8], 1'b0, '0);
		wait_drained();
		finish_test();

		start_test("flag_pass_through");
		for (int i = 0; i < 4; i++)
			dispatch_one(pc_t'('h6000 + 4 * i), 1'b0, i[0], i[1], index[i]);
		for (int i = 3; i >= 0; i--)
			complete_one(index[i], 1'b0, '0);
		wait_drained();
		finish_test();

		total = error_count + i_rob_top.i_rob_properties.failures;
		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, i_rob_top.i_rob_properties.failures);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: flist.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_entry_if.sv
rtl/rob_entry.sv
rtl/reorder_buffer.sv
rtl/rob_top.sv
verif/rob_properties.sv
verif/rob_tb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rob_pkg.sv
      - rtl/rob_entry_if.sv
      - rtl/rob_entry.sv
      - rtl/reorder_buffer.sv
      - rtl/rob_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/rob_properties.sv
      - verif/rob_tb.sv
